//--- verilog/stream_pkg.sv
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Stream payload definitions.
// Data word width, the data word type and the beat struct that
// carries one data word with its end-of-packet flag.
//////////////////////////////////////////////////////////////////////

package stream_pkg;

    // Data bits per beat.
    localparam int DATA_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // One stream beat, 17 bits in total.
    typedef struct packed {
        data_t data;
        logic  last;    // High on the final beat of a packet.
    } beat_t;

endpackage

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Register map definitions.
// Address and word types, register addresses and the bit positions
// of the control and status fields.
//////////////////////////////////////////////////////////////////////

package csr_pkg;

    localparam int ADDR_WIDTH = 2;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] csr_addr_t;
    typedef logic [DATA_WIDTH-1:0] csr_data_t;

    // Register addresses. Address 3 is unused and reads zero.
    localparam csr_addr_t ADDR_CTRL      = 2'd0;
    localparam csr_addr_t ADDR_STATUS    = 2'd1;
    localparam csr_addr_t ADDR_PKT_COUNT = 2'd2;

    // CTRL fields.
    localparam int CTRL_ENABLE_BIT = 0;

    // STATUS fields. The level sits in the low bits.
    localparam int STATUS_LEVEL_WIDTH = 16;
    localparam int STATUS_EMPTY_BIT   = 16;

endpackage

`default_nettype wire

//--- verilog/queue_memory.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// queue_memory
// Synchronous FIFO memory of DEPTH beats. Circular buffer with
// registered read data, a used-word count, an empty flag and an
// almost-full flag raised at DEPTH-1 words.
//////////////////////////////////////////////////////////////////////

module queue_memory #(
    parameter int  DEPTH       = 16,
    localparam int USEDW_WIDTH = $clog2(DEPTH + 1)
) (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  logic                   write,
    input  stream_pkg::beat_t      write_data,
    input  logic                   read,
    output stream_pkg::beat_t      read_data,
    output logic [USEDW_WIDTH-1:0] usedw,
    output logic                   empty,
    output logic                   almost_full
);
    localparam int PTR_WIDTH = $clog2(DEPTH);

    stream_pkg::beat_t mem [DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;

    // Storage array and read port.
    always_ff @(posedge aclk) begin
        if (write) begin
            mem[wr_ptr] <= write_data;
        end
        if (read) begin
            read_data <= mem[rd_ptr];   // Valid after the requesting edge.
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            usedw <= '0;
        end
        else begin
            case ({write, read})
                2'b10:   usedw <= usedw + 1'b1;
                2'b01:   usedw <= usedw - 1'b1;
                default: usedw <= usedw;    // Idle, or write and read together.
            endcase
        end
    end

    always_comb empty = (usedw == '0);
    always_comb almost_full = (usedw >= USEDW_WIDTH'(DEPTH - 1));

endmodule

`default_nettype wire

//--- verilog/basic_queue.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// basic_queue
// Valid/ready queue built on queue_memory. Input ready is registered
// from almost-full, and a two-state FSM keeps one prefetched beat in
// the output stage. Reports the total level and an empty flag.
//////////////////////////////////////////////////////////////////////

module basic_queue #(
    parameter int  DEPTH       = 16,
    localparam int LEVEL_WIDTH = $clog2(DEPTH + 2)
) (
    input  logic                   aclk,
    input  logic                   areset_n,
    input  logic                   rx_tvalid,
    input  stream_pkg::beat_t      rx_tdata,
    output logic                   rx_tready,
    input  logic                   q_tready,
    output logic                   q_tvalid,
    output stream_pkg::beat_t      q_tdata,
    output logic [LEVEL_WIDTH-1:0] level,
    output logic                   empty
);
    localparam int USEDW_WIDTH = $clog2(DEPTH + 1);

    typedef enum logic [0:0] {
        FSM_IDLE,
        FSM_DATA
    } fsm_state_t;

    fsm_state_t fsm_state;

    logic                   write;
    logic                   read;
    logic                   mem_empty;
    logic                   almost_full;
    logic [USEDW_WIDTH-1:0] usedw;
    stream_pkg::beat_t      read_data;

    always_comb write = rx_tvalid && rx_tready;

    // One write may still land after almost_full rises, so the memory
    // tops out at exactly DEPTH words.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            rx_tready <= 1'b0;
        end
        else begin
            rx_tready <= !almost_full;
        end
    end

    queue_memory #(
        .DEPTH(DEPTH)
    ) u_memory (
        .aclk        (aclk),
        .areset_n    (areset_n),
        .write       (write),
        .write_data  (rx_tdata),
        .read        (read),
        .read_data   (read_data),
        .usedw       (usedw),
        .empty       (mem_empty),
        .almost_full (almost_full)
    );

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            fsm_state <= FSM_IDLE;
        end
        else begin
            case (fsm_state)
                FSM_IDLE: if (!mem_empty) fsm_state <= FSM_DATA;
                FSM_DATA: if (q_tready && mem_empty) fsm_state <= FSM_IDLE;
                default:  fsm_state <= FSM_IDLE;
            endcase
        end
    end

    // Prefetch when idle, refill when the output beat is taken.
    always_comb begin
        case (fsm_state)
            FSM_IDLE: read = !mem_empty;
            FSM_DATA: read = !mem_empty && q_tready;
            default:  read = 1'b0;
        endcase
    end

    always_comb q_tvalid = (fsm_state == FSM_DATA);
    always_comb q_tdata = read_data;

    always_comb level = LEVEL_WIDTH'(usedw) + LEVEL_WIDTH'(q_tvalid); // Output stage counts.
    always_comb empty = mem_empty && !q_tvalid;

endmodule

`default_nettype wire

//--- verilog/egress_gate.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// egress_gate
// Output gate that opens and closes only between packets, so a
// started packet always completes. Counts delivered packets, with
// a clear input that wins over a count.
//////////////////////////////////////////////////////////////////////

module egress_gate (
    input  logic                aclk,
    input  logic                areset_n,
    input  logic                enable,
    input  logic                q_tvalid,
    input  stream_pkg::beat_t   q_tdata,
    output logic                q_tready,
    output logic                tx_tvalid,
    output stream_pkg::beat_t   tx_tdata,
    input  logic                tx_tready,
    input  logic                pkt_count_clear,
    output csr_pkg::csr_data_t  packet_count
);
    logic gate_open;
    logic in_packet;
    logic tx_transfer;
    logic at_boundary;

    // Pass-through path with no added latency.
    always_comb tx_tvalid = gate_open && q_tvalid;
    always_comb q_tready = gate_open && tx_tready;
    always_comb tx_tdata = q_tdata;

    always_comb tx_transfer = tx_tvalid && tx_tready;

    // A boundary is the transfer of a last beat, or an idle point
    // between packets with nothing offered on tx.
    always_comb begin
        if (tx_transfer) begin
            at_boundary = tx_tdata.last;
        end
        else begin
            at_boundary = !in_packet && !tx_tvalid;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            in_packet <= 1'b0;
            gate_open <= 1'b0;
        end
        else begin
            if (tx_transfer) begin
                in_packet <= !tx_tdata.last;
            end
            if (at_boundary) begin
                gate_open <= enable;    // Follows enable only between packets.
            end
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            packet_count <= '0;
        end
        else if (pkt_count_clear) begin
            packet_count <= '0;
        end
        else if (tx_transfer && tx_tdata.last) begin
            packet_count <= packet_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_block.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// csr_block
// Control and status registers with write and read strobes.
// Holds CTRL.enable, builds the STATUS word, drives the packet
// counter clear pulse and returns read data one cycle after a read.
//////////////////////////////////////////////////////////////////////

module csr_block (
    input  logic                                   aclk,
    input  logic                                   areset_n,
    input  logic                                   csr_write,
    input  logic                                   csr_read,
    input  csr_pkg::csr_addr_t                     csr_addr,
    input  csr_pkg::csr_data_t                     csr_wdata,
    output csr_pkg::csr_data_t                     csr_rdata,
    output logic                                   csr_rvalid,
    output logic                                   enable,
    output logic                                   pkt_count_clear,
    input  csr_pkg::csr_data_t                     packet_count,
    input  logic [csr_pkg::STATUS_LEVEL_WIDTH-1:0] level,
    input  logic                                   empty
);
    csr_pkg::csr_data_t ctrl_word;
    csr_pkg::csr_data_t status_word;
    csr_pkg::csr_data_t read_word;

    // CTRL register.
    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            enable <= 1'b0;
        end
        else if (csr_write && (csr_addr == csr_pkg::ADDR_CTRL)) begin
            enable <= csr_wdata[csr_pkg::CTRL_ENABLE_BIT];
        end
    end

    // Any write to PKT_COUNT clears the counter in the gate at this edge.
    always_comb pkt_count_clear = csr_write && (csr_addr == csr_pkg::ADDR_PKT_COUNT);

    always_comb begin
        ctrl_word = '0;
        ctrl_word[csr_pkg::CTRL_ENABLE_BIT] = enable;
    end

    always_comb begin
        status_word = '0;
        status_word[csr_pkg::STATUS_LEVEL_WIDTH-1:0] = level;
        status_word[csr_pkg::STATUS_EMPTY_BIT] = empty;
    end

    // Read mux.
    always_comb begin
        case (csr_addr)
            csr_pkg::ADDR_CTRL:      read_word = ctrl_word;
            csr_pkg::ADDR_STATUS:    read_word = status_word;
            csr_pkg::ADDR_PKT_COUNT: read_word = packet_count;
            default:                 read_word = '0;   // Unmapped address.
        endcase
    end

    always_ff @(posedge aclk) begin
        if (csr_read) begin
            csr_rdata <= read_word;
        end
    end

    always_ff @(posedge aclk or negedge areset_n) begin
        if (!areset_n) begin
            csr_rvalid <= 1'b0;
        end
        else begin
            csr_rvalid <= csr_read;     // One-cycle pulse with the data.
        end
    end

endmodule

`default_nettype wire

//--- verilog/stream_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// stream_buffer_top
// Top level of the stream buffer. Connects the queue, the egress
// gate and the register block.
//////////////////////////////////////////////////////////////////////

module stream_buffer_top #(
    parameter int DEPTH = 16
) (
    input  logic               aclk,
    input  logic               areset_n,
    input  logic               rx_tvalid,
    input  stream_pkg::beat_t  rx_tdata,
    output logic               rx_tready,
    output logic               tx_tvalid,
    output stream_pkg::beat_t  tx_tdata,
    input  logic               tx_tready,
    input  logic               csr_write,
    input  logic               csr_read,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_data_t csr_wdata,
    output csr_pkg::csr_data_t csr_rdata,
    output logic               csr_rvalid
);
    localparam int LEVEL_WIDTH = $clog2(DEPTH + 2);

    logic                                   q_tvalid;
    logic                                   q_tready;
    stream_pkg::beat_t                      q_tdata;
    logic [LEVEL_WIDTH-1:0]                 queue_level;
    logic [csr_pkg::STATUS_LEVEL_WIDTH-1:0] status_level;
    logic                                   queue_empty;
    logic                                   enable;
    logic                                   pkt_count_clear;
    csr_pkg::csr_data_t                     packet_count;

    // Widen the level to the STATUS field.
    assign status_level = csr_pkg::STATUS_LEVEL_WIDTH'(queue_level);

    basic_queue #(
        .DEPTH(DEPTH)
    ) u_queue (
        .aclk      (aclk),
        .areset_n  (areset_n),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tready (rx_tready),
        .q_tready  (q_tready),
        .q_tvalid  (q_tvalid),
        .q_tdata   (q_tdata),
        .level     (queue_level),
        .empty     (queue_empty)
    );

    egress_gate u_gate (
        .aclk            (aclk),
        .areset_n        (areset_n),
        .enable          (enable),
        .q_tvalid        (q_tvalid),
        .q_tdata         (q_tdata),
        .q_tready        (q_tready),
        .tx_tvalid       (tx_tvalid),
        .tx_tdata        (tx_tdata),
        .tx_tready       (tx_tready),
        .pkt_count_clear (pkt_count_clear),
        .packet_count    (packet_count)
    );

    csr_block u_csr (
        .aclk            (aclk),
        .areset_n        (areset_n),
        .csr_write       (csr_write),
        .csr_read        (csr_read),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .csr_rdata       (csr_rdata),
        .csr_rvalid      (csr_rvalid),
        .enable          (enable),
        .pkt_count_clear (pkt_count_clear),
        .packet_count    (packet_count),
        .level           (status_level),
        .empty           (queue_empty)
    );

endmodule

`default_nettype wire

//--- test/tb_stream_buffer.sv
`timescale 1ns/1ps
`default_nettype none
//////////////////////////////////////////////////////////////////////
// Testbench for the stream buffer top level.
// Random packet stimulus, a scoreboard with a monitor process,
// a STATUS reference function, compare tasks and a cycle timeout.
//////////////////////////////////////////////////////////////////////

module tb_stream_buffer;

    localparam int DEPTH     = 8;
    localparam int MAX_CYCLES = 20000;     // 300 beats at worst back-pressure plus CSR phases.

    logic               aclk = 1'b0;
    logic               areset_n;
    logic               rx_tvalid;
    stream_pkg::beat_t  rx_tdata;
    logic               rx_tready;
    logic               tx_tvalid;
    stream_pkg::beat_t  tx_tdata;
    logic               tx_tready;
    logic               csr_write;
    logic               csr_read;
    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::csr_data_t csr_wdata;
    csr_pkg::csr_data_t csr_rdata;
    logic               csr_rvalid;

    stream_pkg::beat_t scoreboard [$];
    string             test_name = "reset";
    int                mismatch_errors = 0;
    int                other_errors = 0;
    int                delivered_beats = 0;
    int                model_packets = 0;
    int                cycle_count = 0;
    logic              random_ready = 1'b0;
    logic              prev_csr_read = 1'b0;

    stream_buffer_top #(
        .DEPTH(DEPTH)
    ) u_dut (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .rx_tvalid  (rx_tvalid),
        .rx_tdata   (rx_tdata),
        .rx_tready  (rx_tready),
        .tx_tvalid  (tx_tvalid),
        .tx_tdata   (tx_tdata),
        .tx_tready  (tx_tready),
        .csr_write  (csr_write),
        .csr_read   (csr_read),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .csr_rvalid (csr_rvalid)
    );

    always #2 aclk = ~aclk;    // 4 ns period.

    // STATUS holds the level in bits 15:0 and empty in bit 16.
    function automatic csr_pkg::csr_data_t expected_status(input int beats_in_flight);
        csr_pkg::csr_data_t word;
        word = '0;
        word[15:0] = beats_in_flight[15:0];
        word[16] = (beats_in_flight == 0);
        return word;
    endfunction

    task automatic check_beat(input string name, input stream_pkg::beat_t expected,
                              input stream_pkg::beat_t actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("[FAIL] %s expected data=%h last=%b actual data=%h last=%b",
                     name, expected.data, expected.last, actual.data, actual.last);
        end
    endtask

    task automatic check_word(input string name, input csr_pkg::csr_data_t expected,
                              input csr_pkg::csr_data_t actual);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_error(input string text);
        other_errors++;
        $display("%s", text);
    endtask

    task automatic finish_run();
        $display("Errors: %0d (value mismatches %0d, other failures %0d)",
                 mismatch_errors + other_errors, mismatch_errors, other_errors);
        if (mismatch_errors + other_errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Register access, called and left at a rising edge.
    task automatic write_register(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
        csr_write <= 1'b1;
        csr_addr <= addr;
        csr_wdata <= data;
        @(posedge aclk);
        csr_write <= 1'b0;
    endtask

    task automatic read_and_check(input string name, input csr_pkg::csr_addr_t addr,
                                  input csr_pkg::csr_data_t expected);
        csr_read <= 1'b1;
        csr_addr <= addr;
        @(posedge aclk);
        csr_read <= 1'b0;
        @(posedge aclk);              // Data and valid land one cycle after the strobe.
        if (!csr_rvalid) begin
            report_error($sformatf("No csr_rvalid pulse one cycle after the read in %s.", name));
        end
        check_word(name, expected, csr_rdata);
    endtask

    task automatic send_packet(input int length);
        stream_pkg::beat_t beat;
        for (int i = 0; i < length; i++) begin
            beat.data = stream_pkg::data_t'($urandom);
            beat.last = (i == length - 1);
            rx_tvalid <= 1'b1;
            rx_tdata <= beat;
            do @(posedge aclk); while (!rx_tready);
        end
        rx_tvalid <= 1'b0;
    endtask

    // The first edge lets the monitor record the last accepted beat.
    task automatic wait_drain();
        @(posedge aclk);
        while (scoreboard.size() != 0) @(posedge aclk);
        repeat (4) @(posedge aclk);
    endtask

    // Random back-pressure on tx while random_ready is set.
    always @(posedge aclk) begin
        if (random_ready) tx_tready <= ($urandom_range(0, 3) != 0);
        else tx_tready <= 1'b1;
    end

    // Record accepted rx beats and compare each tx transfer.
    always @(posedge aclk) begin : monitor
        stream_pkg::beat_t expected_beat;
        if (areset_n) begin
            if (tx_tvalid && tx_tready) begin
                if (scoreboard.size() == 0) begin
                    report_error($sformatf("A beat left the DUT with nothing expected in %s.",
                                           test_name));
                end
                else begin
                    expected_beat = scoreboard.pop_front();
                    check_beat(test_name, expected_beat, tx_tdata);
                    if (expected_beat.last) model_packets++;
                end
                delivered_beats++;
            end
            if (rx_tvalid && rx_tready) scoreboard.push_back(rx_tdata);
            if (csr_write && csr_addr == csr_pkg::ADDR_PKT_COUNT) model_packets = 0;
            // A read strobe gives exactly one csr_rvalid cycle, one cycle later.
            if (csr_rvalid !== prev_csr_read) begin
                report_error($sformatf("csr_rvalid was %b after a read strobe of %b in %s.",
                                       csr_rvalid, prev_csr_read, test_name));
            end
            prev_csr_read = csr_read;
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            report_error($sformatf("Timeout after %0d cycles in %s.", cycle_count, test_name));
            finish_run();
        end
    end

    initial begin : stimulus
        stream_pkg::beat_t fill_beat;
        int accepted;
        int low_run;
        int base;
        void'($urandom(32));
        areset_n <= 1'b0;
        rx_tvalid <= 1'b0;
        rx_tdata <= '0;
        tx_tready <= 1'b0;
        csr_write <= 1'b0;
        csr_read <= 1'b0;
        csr_addr <= '0;
        csr_wdata <= '0;

        repeat (4) @(posedge aclk);
        check_word("reset_tx_tvalid", '0, csr_pkg::csr_data_t'(tx_tvalid));
        check_word("reset_csr_rvalid", '0, csr_pkg::csr_data_t'(csr_rvalid));
        repeat (4) @(posedge aclk);
        areset_n <= 1'b1;
        @(posedge aclk);
        check_word("first_edge_tx_tvalid", '0, csr_pkg::csr_data_t'(tx_tvalid));
        check_word("first_edge_csr_rvalid", '0, csr_pkg::csr_data_t'(csr_rvalid));
        read_and_check("reset_ctrl", csr_pkg::ADDR_CTRL, '0);
        read_and_check("reset_status", csr_pkg::ADDR_STATUS, expected_status(0));

        test_name = "ordering";
        write_register(csr_pkg::ADDR_CTRL, 32'h1);
        random_ready <= 1'b1;
        for (int p = 0; p < 40; p++) send_packet($urandom_range(1, 6));
        wait_drain();
        random_ready <= 1'b0;
        read_and_check("count_after_ordering", csr_pkg::ADDR_PKT_COUNT, model_packets);

        // Fill with the gate closed. Every third beat ends a packet.
        test_name = "fill_limit";
        write_register(csr_pkg::ADDR_CTRL, 32'h0);
        accepted = 0;
        low_run = 0;
        fill_beat.data = stream_pkg::data_t'($urandom);
        fill_beat.last = 1'b0;
        rx_tvalid <= 1'b1;
        rx_tdata <= fill_beat;
        while (low_run < 8) begin
            @(posedge aclk);
            if (rx_tready) begin
                accepted++;
                low_run = 0;
                fill_beat.data = stream_pkg::data_t'($urandom);
                fill_beat.last = (accepted % 3 == 2);
                rx_tdata <= fill_beat;
            end
            else low_run++;
        end
        rx_tvalid <= 1'b0;
        check_word("fill_accepted", DEPTH + 1, accepted);
        read_and_check("fill_status", csr_pkg::ADDR_STATUS, expected_status(scoreboard.size()));
        write_register(csr_pkg::ADDR_CTRL, 32'h1);
        wait_drain();

        test_name = "gating";
        write_register(csr_pkg::ADDR_CTRL, 32'h0);
        send_packet(5);
        send_packet(3);
        base = delivered_beats;
        write_register(csr_pkg::ADDR_CTRL, 32'h1);
        while (delivered_beats < base + 1) @(posedge aclk);
        write_register(csr_pkg::ADDR_CTRL, 32'h0);
        repeat (20) @(posedge aclk);
        check_word("gating_hold", base + 5, delivered_beats);
        write_register(csr_pkg::ADDR_CTRL, 32'h1);
        wait_drain();
        check_word("gating_release", base + 8, delivered_beats);

        test_name = "packet_count";
        read_and_check("count_before_clear", csr_pkg::ADDR_PKT_COUNT, model_packets);
        write_register(csr_pkg::ADDR_PKT_COUNT, 32'hffff_ffff);
        read_and_check("count_cleared", csr_pkg::ADDR_PKT_COUNT, '0);
        for (int p = 0; p < 3; p++) send_packet($urandom_range(1, 6));
        wait_drain();
        read_and_check("count_after_clear", csr_pkg::ADDR_PKT_COUNT, model_packets);

        if (scoreboard.size() != 0) begin
            report_error($sformatf("%0d expected beats were never delivered.",
                                   scoreboard.size()));
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- list.f
verilog/stream_pkg.sv
verilog/csr_pkg.sv
verilog/queue_memory.sv
verilog/basic_queue.sv
verilog/egress_gate.sv
verilog/csr_block.sv
verilog/stream_buffer_top.sv
test/tb_stream_buffer.sv

//--- Bender.yml
package:
  name: stream_buffer

sources:
  - verilog/stream_pkg.sv
  - verilog/csr_pkg.sv
  - verilog/queue_memory.sv
  - verilog/basic_queue.sv
  - verilog/egress_gate.sv
  - verilog/csr_block.sv
  - verilog/stream_buffer_top.sv
  - target: test
    files:
      - test/tb_stream_buffer.sv
